// File: compile.f
logic/cpuPkg.sv
logic/regFile.sv
logic/fetch.sv
logic/decode.sv
logic/execute.sv
logic/wordMemory.sv
logic/debugPort.sv
logic/cpuTop.sv
verif/cpuTop_assert.sv
verif/cpuTb.sv

// File: Makefile
# Verilator build and run for the single-cycle core testbench

VERILATOR ?= verilator
TOP       ?= cpuTb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/cpuTb.sv
/*
   CPU testbench
   Directed tests over APB, with a reference model for data memory
*/
`default_nettype none
module cpuTb import cpuPkg::*; ();

   logic        clk;
   logic        reset;
   apbReq_t     apbReq;
   apbRsp_t     apbRsp;
   int          errors;
   int          checks;
   logic [31:0] lfsrState;
   word_t       prog[$];
   logic [7:0]  expAddr[$];
   word_t       expData[$];

   cpuTop UUT (.clk(clk), .reset(reset), .apbReq(apbReq), .apbRsp(apbRsp));

   always #50 clk = ~clk;

   ////////////////////
   // Encoders, opcode in 15:11
   function automatic word_t encI(logic [4:0] op, int rs, int rd, int imm);
      return {op, 3'(rs), 3'(rd), 5'(imm)};
   endfunction

   function automatic word_t encR(int rs, int rt, int rd, int fn);
      return {OP_RTYPE, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
   endfunction

   function automatic word_t encB(logic [4:0] op, int rs, int imm);
      return {op, 3'(rs), 8'(imm)};
   endfunction

   function automatic word_t encJ(logic [4:0] op, int imm);
      return {op, 11'(imm)};
   endfunction

   function automatic logic [9:0] regionAddr(logic [1:0] region, int a);
      return {region, 8'(a)};
   endfunction

   // Background word, differs at every address
   function automatic word_t fillWord(logic [7:0] a);
      return {~a, a};
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsrStep(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic takeBits(input int n, output word_t value);
      value = '0;
      for (int i = 0; i < n; i++) begin
         lfsrState = lfsrStep(lfsrState);
         value = {value[14:0], lfsrState[0]};
      end
   endtask

   ////////////////////
   // Reference model, k 0..3 immediate group, 4..7 register group
   function automatic word_t aluModel(int k, word_t a, word_t b, logic [4:0] i5);
      word_t sx;
      word_t zx;
      sx = {{11{i5[4]}}, i5};
      zx = {11'd0, i5};
      case (k)
         0: return a + sx;
         1: return sx - a;
         2: return a ^ zx;
         3: return a & ~zx;
         4: return a + b;
         5: return b - a;
         6: return a ^ b;
         default: return a & ~b;
      endcase
   endfunction

   // Register value that makes branch type t go the wanted way
   function automatic int condValue(int t, int taken);
      case (t)
         0: return (taken != 0) ? 0 : 5;
         1: return (taken != 0) ? 5 : 0;
         2: return (taken != 0) ? -3 : 5;
         default: return (taken != 0) ? 5 : -3;
      endcase
   endfunction

   task automatic expectEqual(input word_t got, input word_t exp, input string what);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   ////////////////////
   // APB transfer, setup then access
   task automatic busTransfer(input logic write, input logic [9:0] addr, input word_t wdata,
         output word_t rdata, output logic err);
      @(negedge clk);
      apbReq.sel    = 1'b1;
      apbReq.enable = 1'b0;
      apbReq.write  = write;
      apbReq.addr   = addr;
      apbReq.wdata  = wdata;
      @(negedge clk);
      apbReq.enable = 1'b1;
      // Response settled long before the closing edge
      #10;
      rdata = apbRsp.rdata;
      err   = apbRsp.slverr;
      expectEqual(word_t'(apbRsp.ready), 16'd1, "ready in access cycle");
      @(negedge clk);
      apbReq = '0;
   endtask

   task automatic apbWrite(input logic [9:0] addr, input word_t data, output logic err);
      word_t unused;
      busTransfer(1'b1, addr, data, unused, err);
   endtask

   task automatic apbRead(input logic [9:0] addr, output word_t data, output logic err);
      busTransfer(1'b0, addr, '0, data, err);
   endtask

   // Program words, then HALT right after them
   task automatic loadProgram();
      logic err;
      for (int i = 0; i <= prog.size(); i++) begin
         apbWrite(regionAddr(REGION_IMEM, i), (i < prog.size()) ? prog[i] : {OP_HALT, 11'd0},
            err);
         expectEqual(word_t'(err), 16'd0, "slverr on imem load");
      end
   endtask

   task automatic startRun();
      logic err;
      apbWrite(regionAddr(REGION_CTRL, 0), 16'd1 << CTRL_RUN_BIT, err);
      expectEqual(word_t'(err), 16'd0, "slverr on start");
   endtask

   task automatic waitForHalt();
      word_t status;
      logic  err;
      int    polls;
      status = 16'd1;
      polls  = 0;
      while (status[0] && polls < 900) begin
         apbRead(regionAddr(REGION_CTRL, 0), status, err);
         polls++;
      end
      if (status[0]) begin
         errors++;
         $display("Core still running after %0d status polls, HALT never reached", polls);
      end
      // PC advances on the HALT edge too
      expectEqual(UUT.pc, 16'(prog.size() + 1), "pc one past HALT");
   endtask

   task automatic runToHalt();
      startRun();
      waitForHalt();
   endtask

   task automatic addExpected(input int addr, input word_t data);
      expAddr.push_back(8'(addr));
      expData.push_back(data);
   endtask

   task automatic clearResults();
      logic err;
      for (int i = 0; i < expAddr.size(); i++) begin
         apbWrite(regionAddr(REGION_DMEM, int'(expAddr[i])), fillWord(expAddr[i]), err);
      end
   endtask

   task automatic compareDmem();
      word_t got;
      logic  err;
      for (int i = 0; i < expAddr.size(); i++) begin
         apbRead(regionAddr(REGION_DMEM, int'(expAddr[i])), got, err);
         expectEqual(got, expData[i], $sformatf("dmem[%0h]", expAddr[i]));
      end
   endtask

   ////////////////////
   // Directed tests
   task automatic resetState();
      word_t got;
      logic  err;
      expectEqual(UUT.pc, 16'd0, "pc after reset");
      apbRead(regionAddr(REGION_CTRL, 0), got, err);
      expectEqual(got, 16'd0, "running after reset");
      expectEqual(word_t'(err), 16'd0, "slverr on control read");
      apbWrite(regionAddr(REGION_DMEM, 1), fillWord(8'h01), err);
      expectEqual(word_t'(err), 16'd0, "slverr on idle dmem write");
      apbRead(regionAddr(REGION_DMEM, 1), got, err);
      expectEqual(got, fillWord(8'h01), "idle dmem read back");
   endtask

   // Operands built with LBI then SLBI, results stored from 0x10
   task automatic buildAluProgram();
      word_t a;
      word_t b;
      word_t i5;
      prog.delete();
      expAddr.delete();
      expData.delete();
      takeBits(16, a);
      takeBits(16, b);
      takeBits(5, i5);
      prog.push_back(encB(OP_LBI, 1, int'(a[15:8])));
      prog.push_back(encB(OP_SLBI, 1, int'(a[7:0])));
      prog.push_back(encB(OP_LBI, 2, int'(b[15:8])));
      prog.push_back(encB(OP_SLBI, 2, int'(b[7:0])));
      prog.push_back(encB(OP_LBI, 6, 'h10));
      for (int k = 0; k < 8; k++) begin
         if (k < 4) begin
            prog.push_back(encI(5'(OP_ADDI + k), 1, 3, int'(i5[4:0])));
         end else begin
            prog.push_back(encR(1, 2, 3, k - 4));
         end
         prog.push_back(encI(OP_ST, 6, 3, k));
         addExpected('h10 + k, aluModel(k, a, b, i5[4:0]));
      end
   endtask

   task automatic aluGroups();
      buildAluProgram();
      loadProgram();
      clearResults();
      runToHalt();
      compareDmem();
   endtask

   task automatic loadStoreRoundTrip();
      word_t v;
      word_t w;
      word_t c;
      logic  err;
      prog.delete();
      expAddr.delete();
      expData.delete();
      takeBits(16, v);
      takeBits(16, w);
      takeBits(8, c);
      prog.push_back(encB(OP_LBI, 1, int'(v[15:8])));
      prog.push_back(encB(OP_SLBI, 1, int'(v[7:0])));
      prog.push_back(encB(OP_LBI, 6, 'h20));
      prog.push_back(encI(OP_ST, 6, 1, 3));
      prog.push_back(encI(OP_LD, 6, 2, 3));
      prog.push_back(encI(OP_ST, 6, 2, 4));
      prog.push_back(encB(OP_LBI, 3, int'(c[7:0])));
      prog.push_back(encI(OP_ST, 6, 3, 5));
      // Negative offset reaches the host word at 0x30
      prog.push_back(encB(OP_LBI, 5, 'h35));
      prog.push_back(encI(OP_LD, 5, 4, -5));
      prog.push_back(encI(OP_ST, 6, 4, 6));
      addExpected('h23, v);
      addExpected('h24, v);
      addExpected('h25, {{8{c[7]}}, c[7:0]});
      addExpected('h26, w);
      addExpected('h30, w);
      loadProgram();
      clearResults();
      apbWrite(regionAddr(REGION_DMEM, 'h30), w, err);
      runToHalt();
      compareDmem();
   endtask

   // Marker c+1 lands in slot c only when the branch falls through
   task automatic branchesAndJumps();
      int jalAddr;
      int t;
      int taken;
      prog.delete();
      expAddr.delete();
      expData.delete();
      prog.push_back(encB(OP_LBI, 6, 'h40));
      for (int c = 0; c < 8; c++) begin
         t     = c % 4;
         taken = c / 4;
         prog.push_back(encB(OP_LBI, 1, condValue(t, taken)));
         prog.push_back(encB(OP_LBI, 2, c + 1));
         prog.push_back(encB(5'(OP_BEQZ + t), 1, 1));
         prog.push_back(encI(OP_ST, 6, 2, c));
         addExpected('h40 + c, (taken != 0) ? fillWord(8'('h40 + c)) : 16'(c + 1));
      end
      prog.push_back(encJ(OP_J, 1));
      prog.push_back(encI(OP_ST, 6, 2, 8));
      jalAddr = prog.size();
      prog.push_back(encJ(OP_JAL, 1));
      prog.push_back(encI(OP_ST, 6, 2, 10));
      prog.push_back(encI(OP_ST, 6, 7, 9));
      addExpected('h48, fillWord(8'h48));
      addExpected('h4a, fillWord(8'h4a));
      addExpected('h49, 16'(jalAddr + 1));
      loadProgram();
      clearResults();
      runToHalt();
      compareDmem();
   endtask

   // Countdown loop of about 200 cycles keeps the core busy
   task automatic blockedAccess();
      word_t got;
      logic  err;
      prog.delete();
      prog.push_back(encB(OP_LBI, 1, 100));
      prog.push_back(encI(OP_ADDI, 1, 1, -1));
      prog.push_back(encB(OP_BNEZ, 1, -2));
      loadProgram();
      apbWrite(regionAddr(REGION_DMEM, 'h50), fillWord(8'h50), err);
      startRun();
      apbRead(regionAddr(REGION_CTRL, 0), got, err);
      expectEqual(got, 16'd1, "running during loop");
      apbWrite(regionAddr(REGION_DMEM, 'h50), 16'h1234, err);
      expectEqual(word_t'(err), 16'd1, "slverr on dmem write while running");
      apbRead(regionAddr(REGION_DMEM, 'h50), got, err);
      expectEqual(word_t'(err), 16'd1, "slverr on dmem read while running");
      apbWrite(regionAddr(REGION_IMEM, 0), 16'hffff, err);
      expectEqual(word_t'(err), 16'd1, "slverr on imem write while running");
      apbWrite(regionAddr(2'd3, 'h50), 16'h5555, err);
      expectEqual(word_t'(err), 16'd1, "slverr on unmapped write");
      waitForHalt();
      apbRead(regionAddr(REGION_DMEM, 'h50), got, err);
      expectEqual(got, fillWord(8'h50), "dmem word kept");
      expectEqual(word_t'(err), 16'd0, "slverr on dmem read after halt");
      apbRead(regionAddr(REGION_IMEM, 0), got, err);
      expectEqual(got, prog[0], "imem program kept");
      apbRead(regionAddr(2'd3, 'h10), got, err);
      expectEqual(word_t'(err), 16'd1, "slverr on idle unmapped read");
   endtask

   // Same program twice, results wiped in between
   task automatic repeatRun();
      buildAluProgram();
      loadProgram();
      clearResults();
      runToHalt();
      compareDmem();
      clearResults();
      runToHalt();
      compareDmem();
   endtask

   initial begin
      errors    = 0;
      checks    = 0;
      lfsrState = 32'h02ccf859;
      clk       = 1'b0;
      reset     = 1'b1;
      apbReq    = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      resetState();
      aluGroups();
      loadStoreRoundTrip();
      branchesAndJumps();
      blockedAccess();
      repeatRun();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Six tests, 3000 cycles each
   initial begin
      repeat (6 * 3000) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule
`default_nettype wire

// File: verif/cpuTop_assert.sv
/*
   CPU top level assertions
   APB error timing, idle PC and idle data memory checks
*/
`default_nettype none
module cpuTopAssert import cpuPkg::*; (
   input wire     clk,
   input wire     reset,
   input apbReq_t apbReq,
   input apbRsp_t apbRsp,
   input word_t   pc,
   input wire     running,
   input wire     start,
   input wire     memWe
);

   // Error response only in the access phase
   slverrInAccess: assert property (@(posedge clk) disable iff (reset)
      apbRsp.slverr |-> apbReq.enable)
      else $error("slverr raised outside an access cycle");

   // Idle core holds its PC unless a start arrives
   pcHeldWhenIdle: assert property (@(posedge clk) disable iff (reset)
      (!running && !start) |=> $stable(pc))
      else $error("pc moved while the core was idle");

   // A core store only lands in a cycle where the program steps on
   // ST never branches, so the PC moves by exactly one
   noIdleStore: assert property (@(posedge clk) disable iff (reset)
      (memWe && !start) |=> (pc == $past(pc) + 16'd1))
      else $error("data memory write enabled while the core was not stepping");

endmodule

bind cpuTop cpuTopAssert checks (.clk(clk), .reset(reset), .apbReq(apbReq),
   .apbRsp(apbRsp), .pc(pc), .running(running), .start(start), .memWe(memWe));
`default_nettype wire

// File: logic/cpuTop.sv
/*
   CPU top level
   Single-cycle core, instruction and data memories, APB debug port
*/
`default_nettype none
module cpuTop import cpuPkg::*; (
   input  wire     clk,
   input  wire     reset,
   input  apbReq_t apbReq,
   output apbRsp_t apbRsp
);

   word_t pc, instruction, rs, rt, imm, slbiValue, wbData, target;
   word_t memWdata, memRdata, hostWdata, imemHostRdata, dmemHostRdata;
   ctrl_t ctrl;
   regIdx_t destReg;
   logic [DMEM_AW-1:0] memAddr, hostAddr;
   logic branchTaken, memWe, start, running, imemHostWe, dmemHostWe;

   fetch fetchStage (.clk(clk), .reset(reset), .start(start), .running(running),
      .branchTaken(branchTaken), .target(target), .pc(pc));

   // Destination index loops straight back for the single-cycle write
   decode decodeStage (.clk(clk), .reset(reset), .running(running),
      .instruction(instruction), .writeReg(destReg), .writeData(wbData), .ctrl(ctrl),
      .rs(rs), .rt(rt), .imm(imm), .slbiValue(slbiValue), .destReg(destReg));

   execute executeStage (.ctrl(ctrl), .rs(rs), .rt(rt), .imm(imm), .slbiValue(slbiValue),
      .pc(pc), .running(running), .memRdata(memRdata), .aluResult(), .memAddr(memAddr),
      .memWdata(memWdata), .memWe(memWe), .wbData(wbData), .branchTaken(branchTaken),
      .target(target));

   // Core side of instruction memory is read only
   wordMemory #(.addrWidth(IMEM_AW)) imemory (.clk(clk), .coreAddr(pc[IMEM_AW-1:0]),
      .coreWdata('0), .coreWe(1'b0), .coreRdata(instruction), .hostAddr(hostAddr),
      .hostWdata(hostWdata), .hostWe(imemHostWe), .hostRdata(imemHostRdata));

   wordMemory #(.addrWidth(DMEM_AW)) dmemory (.clk(clk), .coreAddr(memAddr),
      .coreWdata(memWdata), .coreWe(memWe), .coreRdata(memRdata), .hostAddr(hostAddr),
      .hostWdata(hostWdata), .hostWe(dmemHostWe), .hostRdata(dmemHostRdata));

   debugPort debug (.clk(clk), .reset(reset), .apbReq(apbReq), .apbRsp(apbRsp),
      .halt(ctrl.halt), .start(start), .running(running), .imemHostWe(imemHostWe),
      .dmemHostWe(dmemHostWe), .hostAddr(hostAddr), .hostWdata(hostWdata),
      .imemHostRdata(imemHostRdata), .dmemHostRdata(dmemHostRdata));

endmodule
`default_nettype wire

// File: logic/debugPort.sv
/*
   APB debug port
   Run control, halt status and host access to both memories
*/
`default_nettype none
module debugPort import cpuPkg::*; (
   input  wire                 clk,
   input  wire                 reset,
   input  apbReq_t             apbReq,
   output apbRsp_t             apbRsp,
   input  wire                 halt,
   output logic                start,
   output logic                running,
   output logic                imemHostWe,
   output logic                dmemHostWe,
   output logic [DMEM_AW-1:0] hostAddr,
   output word_t               hostWdata,
   input  word_t               imemHostRdata,
   input  word_t               dmemHostRdata
);

   logic       access;
   logic [1:0] region;
   logic       isMem;
   logic       blocked;

   // Access phase of a two-cycle transfer
   assign access  = apbReq.sel && apbReq.enable;
   assign region  = apbReq.addr[9:8];
   assign isMem   = (region == REGION_IMEM) || (region == REGION_DMEM);
   // Memories busy while running, top region unmapped
   assign blocked = (isMem && running) || (region == 2'd3);

   assign hostAddr   = apbReq.addr[DMEM_AW-1:0];
   assign hostWdata  = apbReq.wdata;
   assign imemHostWe = access && apbReq.write && !blocked && (region == REGION_IMEM);
   assign dmemHostWe = access && apbReq.write && !blocked && (region == REGION_DMEM);
   assign start      = access && apbReq.write && (region == REGION_CTRL) &&
                       apbReq.wdata[CTRL_RUN_BIT];

   // No wait states
   always_comb begin
      apbRsp.ready  = 1'b1;
      apbRsp.slverr = access && blocked;
      case (region)
         REGION_IMEM: apbRsp.rdata = imemHostRdata;
         REGION_DMEM: apbRsp.rdata = dmemHostRdata;
         REGION_CTRL: apbRsp.rdata = {15'd0, running};
         default:     apbRsp.rdata = '0;
      endcase
   end

   // Start wins over a HALT seen in the same cycle
   always_ff @(posedge clk) begin
      if (reset) begin
         running <= 1'b0;
      end else if (start) begin
         running <= 1'b1;
      end else if (halt) begin
         running <= 1'b0;
      end
   end

endmodule
`default_nettype wire

// File: logic/wordMemory.sv
/*
   Word memory
   RAM with async reads on a core port and a host port
*/
`default_nettype none
module wordMemory import cpuPkg::*; #(
   parameter int addrWidth = IMEM_AW
) (
   input  wire                  clk,
   input  wire [addrWidth-1:0] coreAddr,
   input  word_t                coreWdata,
   input  wire                  coreWe,
   output word_t                coreRdata,
   input  wire [addrWidth-1:0] hostAddr,
   input  word_t                hostWdata,
   input  wire                  hostWe,
   output word_t                hostRdata
);

   word_t mem [2**addrWidth];
   logic  hostLoses;

   assign coreRdata = mem[coreAddr];
   assign hostRdata = mem[hostAddr];

   // Same-address collision goes to the core
   assign hostLoses = coreWe && (coreAddr == hostAddr);

   always_ff @(posedge clk) begin
      if (coreWe) begin
         mem[coreAddr] <= coreWdata;
      end
      if (hostWe && !hostLoses) begin
         mem[hostAddr] <= hostWdata;
      end
   end

endmodule
`default_nettype wire

// File: logic/execute.sv
/*
   Execute stage
   ALU, branch resolution, jump target and writeback select
*/
`default_nettype none
module execute import cpuPkg::*; (
   input  ctrl_t               ctrl,
   input  word_t               rs,
   input  word_t               rt,
   input  word_t               imm,
   input  word_t               slbiValue,
   input  word_t               pc,
   input  wire                 running,
   input  word_t               memRdata,
   output word_t               aluResult,
   output logic [DMEM_AW-1:0] memAddr,
   output word_t               memWdata,
   output logic                memWe,
   output word_t               wbData,
   output logic                branchTaken,
   output word_t               target
);

   word_t opA;
   word_t opB;
   word_t pcPlusOne;
   logic  carryIn;
   logic  condMet;

   ////////////////////
   // ALU
   // Inverting A with carry gives B minus rs
   assign opA     = ctrl.invA ? ~rs : rs;
   assign opB     = ctrl.invB ? ~(ctrl.useImm ? imm : rt) : (ctrl.useImm ? imm : rt);
   assign carryIn = ctrl.invA || ctrl.invB;

   always_comb begin
      case (ctrl.aluOp)
         ALU_XOR: aluResult = opA ^ opB;
         ALU_AND: aluResult = opA & opB;
         default: aluResult = opA + opB + {15'd0, carryIn};
      endcase
   end

   // Data memory, ST stores the register in bits 7:5
   assign memAddr  = aluResult[DMEM_AW-1:0];
   assign memWdata = rt;
   assign memWe    = ctrl.memWrite && running;

   ////////////////////
   // Branch and jump
   always_comb begin
      case (ctrl.brType)
         2'b00:   condMet = (rs == '0);
         2'b01:   condMet = (rs != '0);
         2'b10:   condMet = rs[15];
         default: condMet = !rs[15];
      endcase
   end

   // imm is already imm8 for branches, imm11 for J and JAL
   assign pcPlusOne   = pc + 16'd1;
   assign target      = pcPlusOne + imm;
   assign branchTaken = ctrl.jump || (ctrl.isBranch && condMet);

   // Writeback
   always_comb begin
      case (ctrl.wbSrc)
         WB_MEM:  wbData = memRdata;
         WB_BSRC: wbData = ctrl.zeroExt ? slbiValue : imm;
         WB_LINK: wbData = pcPlusOne;
         default: wbData = aluResult;
      endcase
   end

endmodule
`default_nettype wire

// File: logic/decode.sv
/*
   Decode stage
   Control decode, immediate extension and the register file
*/
`default_nettype none
module decode import cpuPkg::*; (
   input  wire     clk,
   input  wire     reset,
   input  wire     running,
   input  word_t   instruction,
   input  regIdx_t writeReg,
   input  word_t   writeData,
   output ctrl_t   ctrl,
   output word_t   rs,
   output word_t   rt,
   output word_t   imm,
   output word_t   slbiValue,
   output regIdx_t destReg
);

   logic [4:0] opcode;
   logic [1:0] func;
   logic       useFive;
   word_t      imm5;
   word_t      imm8;
   word_t      imm11;

   assign opcode = instruction[15:11];
   assign func   = instruction[1:0];

   ////////////////////
   // Control signals
   always_comb begin
      ctrl = '0;
      case (opcode)
         OP_HALT: ctrl.halt = 1'b1;
         // Immediate ALU group, rd in bits 7:5
         OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = DST_RT;
            ctrl.wbSrc    = WB_ALU;
            ctrl.useImm   = 1'b1;
            ctrl.aluOp    = (opcode == OP_XORI)  ? ALU_XOR :
                            (opcode == OP_ANDNI) ? ALU_AND : ALU_ADD;
            ctrl.invA     = (opcode == OP_SUBI);
            ctrl.invB     = (opcode == OP_ANDNI);
            ctrl.zeroExt  = opcode[1];
         end
         OP_RTYPE: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = DST_RD;
            ctrl.wbSrc    = WB_ALU;
            ctrl.aluOp    = (func == FN_XOR)  ? ALU_XOR :
                            (func == FN_ANDN) ? ALU_AND : ALU_ADD;
            ctrl.invA     = (func == FN_SUB);
            ctrl.invB     = (func == FN_ANDN);
         end
         // Address is rs plus imm5
         OP_ST: begin
            ctrl.memWrite = 1'b1;
            ctrl.useImm   = 1'b1;
         end
         OP_LD: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = DST_RT;
            ctrl.wbSrc    = WB_MEM;
            ctrl.useImm   = 1'b1;
         end
         // Byte loads write rs, SLBI marked by its zero-extended imm8
         OP_LBI, OP_SLBI: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = DST_RS;
            ctrl.wbSrc    = WB_BSRC;
            ctrl.zeroExt  = (opcode == OP_SLBI);
         end
         OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
            ctrl.isBranch = 1'b1;
            ctrl.brType   = opcode[1:0];
         end
         OP_J: ctrl.jump = 1'b1;
         OP_JAL: begin
            ctrl.jump     = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = DST_R7;
            ctrl.wbSrc    = WB_LINK;
         end
         // NOP and anything outside the subset do nothing
         default: ctrl = '0;
      endcase
   end

   ////////////////////
   // Immediates
   assign imm5  = ctrl.zeroExt ? {11'd0, instruction[4:0]}
                               : {{11{instruction[4]}}, instruction[4:0]};
   assign imm8  = ctrl.zeroExt ? {8'd0, instruction[7:0]}
                               : {{8{instruction[7]}}, instruction[7:0]};
   assign imm11 = {{5{instruction[10]}}, instruction[10:0]};

   // imm5 for the immediate ALU group and memory ops
   assign useFive = (opcode[4:2] == 3'b010) || (opcode == OP_ST) || (opcode == OP_LD);
   assign imm     = ctrl.jump ? imm11 : (useFive ? imm5 : imm8);

   // Old low byte of rs moves up
   assign slbiValue = {rs[7:0], instruction[7:0]};

   always_comb begin
      case (ctrl.regDst)
         DST_RS:  destReg = instruction[10:8];
         DST_RT:  destReg = instruction[7:5];
         DST_RD:  destReg = instruction[4:2];
         default: destReg = 3'd7;
      endcase
   end

   // Writes only land while the core runs
   regFile regs (
      .clk(clk), .reset(reset),
      .read1Sel(instruction[10:8]), .read2Sel(instruction[7:5]),
      .writeSel(writeReg), .writeData(writeData), .writeEn(ctrl.regWrite && running),
      .read1Data(rs), .read2Data(rt)
   );

endmodule
`default_nettype wire

// File: logic/fetch.sv
/*
   Fetch
   Program counter with next-PC selection
*/
`default_nettype none
module fetch import cpuPkg::*; (
   input  wire   clk,
   input  wire   reset,
   input  wire   start,
   input  wire   running,
   input  wire   branchTaken,
   input  word_t target,
   output word_t pc
);

   word_t nextPc;

   // Taken branch or jump overrides the sequential PC
   // Word addressed, so sequential is plus one
   assign nextPc = branchTaken ? target : pc + 16'd1;

   // Start restarts the program at address zero
   always_ff @(posedge clk) begin
      if (reset || start) begin
         pc <= '0;
      end else if (running) begin
         pc <= nextPc;
      end
   end

endmodule
`default_nettype wire

// File: logic/regFile.sv
/*
   Register file
   Eight 16-bit registers, two async reads and one sync write
*/
`default_nettype none
module regFile import cpuPkg::*; (
   input  wire     clk,
   input  wire     reset,
   input  regIdx_t read1Sel,
   input  regIdx_t read2Sel,
   input  regIdx_t writeSel,
   input  word_t   writeData,
   input  wire     writeEn,
   output word_t   read1Data,
   output word_t   read2Data
);

   word_t regs [8];

   // Reads see the old value during a write
   assign read1Data = regs[read1Sel];
   assign read2Data = regs[read2Sel];

   always_ff @(posedge clk) begin
      if (reset) begin
         regs <= '{default: '0};
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

endmodule
`default_nettype wire

// File: logic/cpuPkg.sv
/*
   CPU package
   Shared word types, opcodes, APB map and control structs for the core
*/
`default_nettype none
package cpuPkg;

   // Data and instruction word, register index
   typedef logic [15:0] word_t;
   typedef logic [2:0]  regIdx_t;

   // Word-addressed memories, 256 words each
   localparam int IMEM_AW = 8;
   localparam int DMEM_AW = 8;

   ////////////////////
   // Opcodes, bits 15:11
   localparam logic [4:0] OP_HALT  = 5'b00000;
   localparam logic [4:0] OP_NOP   = 5'b00001;
   localparam logic [4:0] OP_ADDI  = 5'b01000;
   localparam logic [4:0] OP_SUBI  = 5'b01001;
   localparam logic [4:0] OP_XORI  = 5'b01010;
   localparam logic [4:0] OP_ANDNI = 5'b01011;
   localparam logic [4:0] OP_ST    = 5'b10000;
   localparam logic [4:0] OP_LD    = 5'b10001;
   localparam logic [4:0] OP_SLBI  = 5'b10010;
   localparam logic [4:0] OP_LBI   = 5'b11000;
   localparam logic [4:0] OP_RTYPE = 5'b11011;
   localparam logic [4:0] OP_BEQZ  = 5'b01100;
   localparam logic [4:0] OP_BNEZ  = 5'b01101;
   localparam logic [4:0] OP_BLTZ  = 5'b01110;
   localparam logic [4:0] OP_BGEZ  = 5'b01111;
   localparam logic [4:0] OP_J     = 5'b00100;
   localparam logic [4:0] OP_JAL   = 5'b00110;

   // Register-register function field, bits 1:0
   localparam logic [1:0] FN_ADD  = 2'b00;
   localparam logic [1:0] FN_SUB  = 2'b01;
   localparam logic [1:0] FN_XOR  = 2'b10;
   localparam logic [1:0] FN_ANDN = 2'b11;

   // ALU operations
   localparam logic [1:0] ALU_ADD = 2'd0;
   localparam logic [1:0] ALU_XOR = 2'd1;
   localparam logic [1:0] ALU_AND = 2'd2;

   // Writeback sources
   localparam logic [1:0] WB_ALU  = 2'd0;
   localparam logic [1:0] WB_MEM  = 2'd1;
   localparam logic [1:0] WB_BSRC = 2'd2;
   localparam logic [1:0] WB_LINK = 2'd3;

   // Destination field select: 10:8, 7:5, 4:2 or fixed R7
   localparam logic [1:0] DST_RS = 2'd0;
   localparam logic [1:0] DST_RT = 2'd1;
   localparam logic [1:0] DST_RD = 2'd2;
   localparam logic [1:0] DST_R7 = 2'd3;

   ////////////////////
   // APB map, region in word address bits 9:8
   localparam logic [1:0] REGION_IMEM  = 2'd0;
   localparam logic [1:0] REGION_DMEM  = 2'd1;
   localparam logic [1:0] REGION_CTRL  = 2'd2;
   localparam int         CTRL_RUN_BIT = 0;

   typedef struct packed {
      logic       regWrite;
      logic [1:0] regDst;
      logic [1:0] wbSrc;
      logic       useImm;
      logic [1:0] aluOp;
      logic       invA;
      logic       invB;
      logic       memWrite;
      logic       isBranch;
      logic [1:0] brType;
      logic       jump;
      logic       halt;
      logic       zeroExt;
   } ctrl_t;

   typedef struct packed {
      logic       sel;
      logic       enable;
      logic       write;
      logic [9:0] addr;
      word_t      wdata;
   } apbReq_t;

   typedef struct packed {
      word_t rdata;
      logic  ready;
      logic  slverr;
   } apbRsp_t;

endpackage
`default_nettype wire
